// ==== rtl/srpt_defs.svh ====
`ifndef SRPT_DEFS_SVH
`define SRPT_DEFS_SVH

// queue depth in entries
`define SRPT_DEPTH 16

// field widths
`define PEER_ID_W 14
`define RPC_ID_W 14
`define PKT_CNT_W 10
`define OFFSET_W 32
`define STATE_W 3
`define ENTRY_W 51
`define HDR_W 80

// queue entry layout, state code in the low bits
`define ENTRY_PEER 50:37
`define ENTRY_RPC 36:23
`define ENTRY_RECV 22:13
`define ENTRY_GRANTABLE 12:3
`define ENTRY_STATE 2:0

// header word layout as delivered by the packet parser
`define HDR_PEER 79:66
`define HDR_RPC 65:52
`define HDR_MSG_LEN 51:42
`define HDR_INCOMING 41:32
`define HDR_OFFSET 31:0

// entry state codes
`define STATE_EMPTY 3'b100
`define STATE_ACTIVE 3'b110

`endif

// ==== rtl/srpt_entry_pkg.sv ====
`include "srpt_defs.svh"

package srpt_entry_pkg;

   // id and count vectors
   typedef logic [`PEER_ID_W-1:0] peer_id_t;
   typedef logic [`RPC_ID_W-1:0] rpc_id_t;
   typedef logic [`PKT_CNT_W-1:0] pkt_cnt_t;

   // one queue entry: peer, rpc, recv, grantable, state
   typedef logic [`ENTRY_W-1:0] srpt_entry_t;

   typedef enum logic [`STATE_W-1:0] {
      EMPTY  = `STATE_EMPTY,
      ACTIVE = `STATE_ACTIVE
   } srpt_state_e;

   // which neighbour pairs the sort network compares
   typedef enum logic {
      EVEN_PHASE = 1'b0,
      ODD_PHASE  = 1'b1
   } swap_phase_e;

   // true when a belongs nearer the head than b
   function automatic logic srpt_before(srpt_entry_t a, srpt_entry_t b);
      srpt_state_e a_state;
      srpt_state_e b_state;
      a_state = srpt_state_e'(a[`ENTRY_STATE]);
      b_state = srpt_state_e'(b[`ENTRY_STATE]);
      // active always beats empty
      if (a_state == ACTIVE && b_state != ACTIVE) begin
         return 1'b1;
      end
      // both active: fewer grantable packets wins, ties keep their order
      if (a_state == ACTIVE && b_state == ACTIVE) begin
         return a[`ENTRY_GRANTABLE] < b[`ENTRY_GRANTABLE];
      end
      return 1'b0;
   endfunction

endpackage

// ==== rtl/homa_hdr_pkg.sv ====
`include "srpt_defs.svh"

package homa_hdr_pkg;

   // full header word from the header FIFO
   // peer, rpc, message length, incoming, byte offset
   typedef logic [`HDR_W-1:0] homa_hdr_t;

   // byte offset of the packet within its message
   // zero marks the first packet
   typedef logic [`OFFSET_W-1:0] byte_offset_t;

endpackage

// ==== rtl/header_intake.sv ====
`include "srpt_defs.svh"

module header_intake (
   input  logic                         ap_clk,
   input  logic                         ap_rst,
   input  logic                         header_empty_i,
   input  homa_hdr_pkg::homa_hdr_t      header_data_i,
   output logic                         header_rd_o,
   output logic                         push_o,
   output srpt_entry_pkg::srpt_entry_t  push_entry_o,
   output logic                         upd_o,
   output srpt_entry_pkg::peer_id_t     upd_peer_o,
   output srpt_entry_pkg::rpc_id_t      upd_rpc_o
);

   // decoded header fields
   srpt_entry_pkg::peer_id_t     hdr_peer;
   srpt_entry_pkg::rpc_id_t      hdr_rpc;
   srpt_entry_pkg::pkt_cnt_t     hdr_msg_len;
   srpt_entry_pkg::pkt_cnt_t     hdr_incoming;
   homa_hdr_pkg::byte_offset_t   hdr_offset;

   srpt_entry_pkg::pkt_cnt_t     grantable;
   logic                         has_grantable;
   logic                         first_pkt;
   srpt_entry_pkg::srpt_entry_t  new_entry;

   // fwft FIFO, so the word is taken in the cycle it shows up
   assign header_rd_o = ~header_empty_i;

   assign hdr_peer     = header_data_i[`HDR_PEER];
   assign hdr_rpc      = header_data_i[`HDR_RPC];
   assign hdr_msg_len  = header_data_i[`HDR_MSG_LEN];
   assign hdr_incoming = header_data_i[`HDR_INCOMING];
   assign hdr_offset   = header_data_i[`HDR_OFFSET];

   // packets still to be granted beyond the unscheduled part
   assign grantable     = hdr_msg_len - hdr_incoming;
   assign has_grantable = hdr_msg_len > hdr_incoming;
   assign first_pkt     = hdr_offset == '0;

   // fresh entry, this packet counts as the first received
   always_comb begin
      new_entry                   = '0;
      new_entry[`ENTRY_PEER]      = hdr_peer;
      new_entry[`ENTRY_RPC]       = hdr_rpc;
      new_entry[`ENTRY_RECV]      = srpt_entry_pkg::pkt_cnt_t'(1);
      new_entry[`ENTRY_GRANTABLE] = grantable;
      new_entry[`ENTRY_STATE]     = srpt_entry_pkg::ACTIVE;
   end

   // strobes, at most one per consumed header
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         push_o <= 1'b0;
         upd_o  <= 1'b0;
      end else begin
         push_o <= header_rd_o && has_grantable && first_pkt;
         upd_o  <= header_rd_o && has_grantable && !first_pkt;
      end
   end

   // payload follows the strobes, loaded only on a consumed word
   always_ff @(posedge ap_clk) begin
      if (header_rd_o) begin
         push_entry_o <= new_entry;
         upd_peer_o   <= hdr_peer;
         upd_rpc_o    <= hdr_rpc;
      end
   end

endmodule

// ==== rtl/srpt_queue.sv ====
`include "srpt_defs.svh"

module srpt_queue #(
   parameter int DEPTH = `SRPT_DEPTH
) (
   input  logic                         ap_clk,
   input  logic                         ap_rst,
   input  logic                         push_i,
   input  srpt_entry_pkg::srpt_entry_t  push_entry_i,
   input  logic                         upd_i,
   input  srpt_entry_pkg::peer_id_t     upd_peer_i,
   input  srpt_entry_pkg::rpc_id_t      upd_rpc_i,
   input  logic                         grant_full_i,
   output logic                         grant_wr_o,
   output srpt_entry_pkg::srpt_entry_t  grant_data_o
);

   // all-zero entry carrying the empty code
   localparam srpt_entry_pkg::srpt_entry_t EMPTY_ENTRY =
      srpt_entry_pkg::srpt_entry_t'(srpt_entry_pkg::EMPTY);

   // entry 0 is the head
   srpt_entry_pkg::srpt_entry_t  queue_q [DEPTH];
   srpt_entry_pkg::swap_phase_e  phase_q;

   // candidate next state of each operation
   srpt_entry_pkg::srpt_entry_t  push_q [DEPTH];
   srpt_entry_pkg::srpt_entry_t  upd_q  [DEPTH];
   srpt_entry_pkg::srpt_entry_t  pop_q  [DEPTH];
   srpt_entry_pkg::srpt_entry_t  sort_q [DEPTH];

   srpt_entry_pkg::srpt_state_e  head_state;
   logic                         head_active;
   logic                         new_first;
   logic                         pop_go;
   logic                         odd_sel;

   assign head_state  = srpt_entry_pkg::srpt_state_e'(queue_q[0][`ENTRY_STATE]);
   assign head_active = head_state == srpt_entry_pkg::ACTIVE;

   // pop only when nothing else claims the array this cycle
   assign pop_go = head_active && !grant_full_i && !push_i && !upd_i;

   // push compares the new entry with the head and the loser lands at 1
   assign new_first = srpt_entry_pkg::srpt_before(push_entry_i, queue_q[0]);

   always_comb begin
      push_q[0] = new_first ? push_entry_i : queue_q[0];
      push_q[1] = new_first ? queue_q[0] : push_entry_i;
      // rest moves one toward the tail and the last entry falls off
      for (int i = 2; i < DEPTH; i++) begin
         push_q[i] = queue_q[i-1];
      end
   end

   // update bumps recv on every active entry with matching ids
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         upd_q[i] = queue_q[i];
         if (queue_q[i][`ENTRY_STATE] == srpt_entry_pkg::ACTIVE &&
             queue_q[i][`ENTRY_PEER] == upd_peer_i &&
             queue_q[i][`ENTRY_RPC] == upd_rpc_i) begin
            upd_q[i][`ENTRY_RECV] = queue_q[i][`ENTRY_RECV] + srpt_entry_pkg::pkt_cnt_t'(1);
         end
      end
   end

   // pop shifts toward the head and empty fills the tail
   always_comb begin
      for (int i = 0; i < DEPTH - 1; i++) begin
         pop_q[i] = queue_q[i+1];
      end
      pop_q[DEPTH-1] = EMPTY_ENTRY;
   end

   // even phase compares pairs starting at even slots
   // odd phase compares pairs starting at odd slots
   assign odd_sel = phase_q == srpt_entry_pkg::ODD_PHASE;

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         sort_q[i] = queue_q[i];
      end
      for (int i = 0; i < DEPTH - 1; i++) begin
         // pairs are disjoint so each slot is written at most once
         if ((i % 2 == 1) == odd_sel &&
             srpt_entry_pkg::srpt_before(queue_q[i+1], queue_q[i])) begin
            sort_q[i]   = queue_q[i+1];
            sort_q[i+1] = queue_q[i];
         end
      end
   end

   // array update with push over update over pop over sort
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            queue_q[i] <= EMPTY_ENTRY;
         end
         phase_q <= srpt_entry_pkg::EVEN_PHASE;
      end else if (push_i) begin
         queue_q <= push_q;
      end else if (upd_i) begin
         queue_q <= upd_q;
      end else if (pop_go) begin
         queue_q <= pop_q;
      end else begin
         queue_q <= sort_q;
         // phase advances only on sort cycles
         phase_q <= odd_sel ? srpt_entry_pkg::EVEN_PHASE : srpt_entry_pkg::ODD_PHASE;
      end
   end

   // grant write strobe one cycle after the pop decision
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         grant_wr_o <= 1'b0;
      end else begin
         grant_wr_o <= pop_go;
      end
   end

   // head captured as it leaves
   always_ff @(posedge ap_clk) begin
      if (pop_go) begin
         grant_data_o <= queue_q[0];
      end
   end

endmodule

// ==== rtl/srpt_grant_top.sv ====
module srpt_grant_top (
   input  logic                         ap_clk,
   input  logic                         ap_rst,
   input  logic                         header_empty_i,
   input  homa_hdr_pkg::homa_hdr_t      header_data_i,
   output logic                         header_rd_o,
   input  logic                         grant_full_i,
   output logic                         grant_wr_o,
   output srpt_entry_pkg::srpt_entry_t  grant_data_o
);

   // intake to queue strobes and payload
   logic                         push;
   srpt_entry_pkg::srpt_entry_t  push_entry;
   logic                         upd;
   srpt_entry_pkg::peer_id_t     upd_peer;
   srpt_entry_pkg::rpc_id_t      upd_rpc;

   // header decode, one registered stage
   header_intake header_intake_inst (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_empty_i (header_empty_i),
      .header_data_i  (header_data_i),
      .header_rd_o    (header_rd_o),
      .push_o         (push),
      .push_entry_o   (push_entry),
      .upd_o          (upd),
      .upd_peer_o     (upd_peer),
      .upd_rpc_o      (upd_rpc)
   );

   // sorted store and grant output
   srpt_queue srpt_queue_inst (
      .ap_clk       (ap_clk),
      .ap_rst       (ap_rst),
      .push_i       (push),
      .push_entry_i (push_entry),
      .upd_i        (upd),
      .upd_peer_i   (upd_peer),
      .upd_rpc_i    (upd_rpc),
      .grant_full_i (grant_full_i),
      .grant_wr_o   (grant_wr_o),
      .grant_data_o (grant_data_o)
   );

endmodule

// ==== dv/srpt_grant_props.sv ====
`include "srpt_defs.svh"

module srpt_grant_props (
   input  logic                         ap_clk,
   input  logic                         ap_rst,
   input  logic                         header_empty_i,
   input  logic                         header_rd_i,
   input  logic                         grant_full_i,
   input  logic                         grant_wr_i,
   input  srpt_entry_pkg::srpt_entry_t  grant_data_i
);

   // running count of assertion failures
   int assert_fail_cnt = 0;

   // fwft read only when a word is present
   rd_only_when_present: assert property (
      @(posedge ap_clk) disable iff (ap_rst) !(header_rd_i && header_empty_i)
   ) else begin
      assert_fail_cnt++;
      $error("header read while the header FIFO was empty");
   end

   // a granted entry is always a live one
   grant_is_active: assert property (
      @(posedge ap_clk) disable iff (ap_rst)
      grant_wr_i |-> grant_data_i[`ENTRY_STATE] == `STATE_ACTIVE
   ) else begin
      assert_fail_cnt++;
      $error("grant written with a non-active state code");
   end

   // full blocks the pop decision, so no write one cycle later
   no_grant_after_full: assert property (
      @(posedge ap_clk) disable iff (ap_rst) grant_full_i |=> !grant_wr_i
   ) else begin
      assert_fail_cnt++;
      $error("grant written in the cycle after the grant FIFO was full");
   end

   // first cycle out of reset
   quiet_after_reset: assert property (
      @(posedge ap_clk) $fell(ap_rst) |-> !grant_wr_i
   ) else begin
      assert_fail_cnt++;
      $error("grant written in the first cycle after reset");
   end

endmodule

// ==== dv/srpt_grant_checker.sv ====
module srpt_grant_checker (
   input  logic                         ap_clk,
   input  logic                         ap_rst,
   input  logic                         header_empty_i,
   input  logic                         header_rd_i,
   input  logic                         grant_wr_i,
   input  srpt_entry_pkg::srpt_entry_t  grant_data_i
);

   // expected grants, next one at the front
   srpt_entry_pkg::srpt_entry_t exp_q [$];

   // per-test tallies, cleared when a test closes
   int test_errs = 0;
   int read_cnt  = 0;

   // run totals
   int pass_cnt = 0;
   int fail_cnt = 0;

   function automatic int pending();
      return exp_q.size();
   endfunction

   task automatic expect_grant(input srpt_entry_pkg::srpt_entry_t entry);
      exp_q.push_back(entry);
   endtask

   // negedge, so registered outputs and driven inputs are settled
   always @(negedge ap_clk) begin
      srpt_entry_pkg::srpt_entry_t exp_entry;
      if (!ap_rst) begin
         // fwft: a read in every cycle with a word present, never otherwise
         if (header_rd_i !== ~header_empty_i) begin
            $display("FAILED header_rd_o expected %h actual %h", ~header_empty_i, header_rd_i);
            test_errs++;
         end
         if (header_rd_i) begin
            read_cnt++;
         end
         if (grant_wr_i) begin
            if (exp_q.size() == 0) begin
               $display("unexpected grant %h written with nothing left to grant", grant_data_i);
               test_errs++;
            end else begin
               exp_entry = exp_q.pop_front();
               if (grant_data_i !== exp_entry) begin
                  $display("FAILED grant_data_o expected %h actual %h", exp_entry, grant_data_i);
                  test_errs++;
               end
            end
         end
      end
   end

   // close a test: leftovers and read count, then one result line
   task automatic finish_test(input string name, input int exp_reads);
      if (exp_q.size() != 0) begin
         $display("%s: %0d expected grants never arrived", name, exp_q.size());
         test_errs++;
         exp_q.delete();
      end
      if (read_cnt != exp_reads) begin
         $display("%s: %0d headers consumed but %0d were sent", name, read_cnt, exp_reads);
         test_errs++;
      end
      if (test_errs == 0) begin
         pass_cnt++;
         $display("test %s PASS", name);
      end else begin
         fail_cnt++;
         $display("test %s FAIL with %0d errors", name, test_errs);
      end
      test_errs = 0;
      read_cnt  = 0;
   endtask

endmodule

// ==== dv/tb_srpt_grant.sv ====
`include "srpt_defs.svh"

module tb_srpt_grant;

   // cycle budget per test, summed, doubled for the timeout
   localparam int TEST_CYCLES    = 40 + 150 + 250 + 150 + 160;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
   // enough quiet cycles for a full sort pass
   localparam int IDLE_WAIT = `SRPT_DEPTH + 2;
   localparam int ORDER_CNT = 8;

   logic                         ap_clk;
   logic                         ap_rst;
   logic                         header_empty_i;
   homa_hdr_pkg::homa_hdr_t      header_data_i;
   logic                         header_rd_o;
   logic                         grant_full_i;
   logic                         grant_wr_o;
   srpt_entry_pkg::srpt_entry_t  grant_data_o;

   // header FIFO contents, front is the word on header_data_i
   homa_hdr_pkg::homa_hdr_t fifo_q [$];
   int cycle_cnt = 0;

   srpt_grant_top srpt_grant_top_inst (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_empty_i (header_empty_i),
      .header_data_i  (header_data_i),
      .header_rd_o    (header_rd_o),
      .grant_full_i   (grant_full_i),
      .grant_wr_o     (grant_wr_o),
      .grant_data_o   (grant_data_o)
   );

   srpt_grant_checker checker_inst (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_empty_i (header_empty_i),
      .header_rd_i    (header_rd_o),
      .grant_wr_i     (grant_wr_o),
      .grant_data_i   (grant_data_o)
   );

   bind srpt_grant_top srpt_grant_props srpt_grant_props_inst (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_empty_i (header_empty_i),
      .header_rd_i    (header_rd_o),
      .grant_full_i   (grant_full_i),
      .grant_wr_i     (grant_wr_o),
      .grant_data_i   (grant_data_o)
   );

   initial begin
      ap_clk = 1'b0;
      forever begin
         #2;
         ap_clk = ~ap_clk;
      end
   end

   // fwft FIFO model: pop on a read at the edge, show the new front 1 unit later
   initial begin
      header_empty_i = 1'b1;
      header_data_i  = '0;
      forever begin
         @(posedge ap_clk);
         if (header_rd_o && fifo_q.size() != 0) begin
            fifo_q.delete(0);
         end
         #1;
         header_empty_i = fifo_q.size() == 0;
         header_data_i  = fifo_q.size() != 0 ? fifo_q[0] : '0;
      end
   end

   always @(posedge ap_clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("timeout after %0d cycles, grants or headers still outstanding", cycle_cnt);
      $display("tests failed");
      $finish;
   end

   function automatic homa_hdr_pkg::homa_hdr_t make_header(
      input srpt_entry_pkg::peer_id_t   peer,
      input srpt_entry_pkg::rpc_id_t    rpc,
      input srpt_entry_pkg::pkt_cnt_t   msg_len,
      input srpt_entry_pkg::pkt_cnt_t   incoming,
      input homa_hdr_pkg::byte_offset_t offset
   );
      homa_hdr_pkg::homa_hdr_t hdr;
      hdr                = '0;
      hdr[`HDR_PEER]     = peer;
      hdr[`HDR_RPC]      = rpc;
      hdr[`HDR_MSG_LEN]  = msg_len;
      hdr[`HDR_INCOMING] = incoming;
      hdr[`HDR_OFFSET]   = offset;
      return hdr;
   endfunction

   // reference model: the grant word a first packet should end up as
   function automatic srpt_entry_pkg::srpt_entry_t expected_entry(
      input homa_hdr_pkg::homa_hdr_t  hdr,
      input srpt_entry_pkg::pkt_cnt_t recv
   );
      srpt_entry_pkg::srpt_entry_t entry;
      entry                   = '0;
      entry[`ENTRY_PEER]      = hdr[`HDR_PEER];
      entry[`ENTRY_RPC]       = hdr[`HDR_RPC];
      entry[`ENTRY_RECV]      = recv;
      entry[`ENTRY_GRANTABLE] = hdr[`HDR_MSG_LEN] - hdr[`HDR_INCOMING];
      entry[`ENTRY_STATE]     = `STATE_ACTIVE;
      return entry;
   endfunction

   task automatic send_header(input homa_hdr_pkg::homa_hdr_t hdr);
      @(posedge ap_clk);
      fifo_q.push_back(hdr);
   endtask

   task automatic set_grant_full(input logic full);
      @(posedge ap_clk);
      #1;
      grant_full_i = full;
   endtask

   // headers consumed and every expected grant seen
   task automatic wait_drained();
      while (fifo_q.size() != 0 || checker_inst.pending() != 0) begin
         @(posedge ap_clk);
      end
   endtask

   // eight messages, distinct grantable counts, released in one go
   task automatic run_grant_order();
      homa_hdr_pkg::homa_hdr_t      hdrs [ORDER_CNT];
      srpt_entry_pkg::srpt_entry_t  exp [ORDER_CNT];
      srpt_entry_pkg::srpt_entry_t  tmp;
      srpt_entry_pkg::pkt_cnt_t     incoming;
      srpt_entry_pkg::pkt_cnt_t     grantable;
      logic                         taken;
      set_grant_full(1'b1);
      for (int i = 0; i < ORDER_CNT; i++) begin
         taken = 1'b1;
         while (taken) begin
            grantable = srpt_entry_pkg::pkt_cnt_t'($urandom_range(1, 400));
            taken     = 1'b0;
            for (int k = 0; k < i; k++) begin
               if (exp[k][`ENTRY_GRANTABLE] == grantable) begin
                  taken = 1'b1;
               end
            end
         end
         incoming = srpt_entry_pkg::pkt_cnt_t'($urandom_range(0, 100));
         hdrs[i]  = make_header(srpt_entry_pkg::peer_id_t'($urandom),
                                srpt_entry_pkg::rpc_id_t'($urandom),
                                incoming + grantable, incoming, 32'd0);
         exp[i]   = expected_entry(hdrs[i], 10'd1);
         send_header(hdrs[i]);
      end
      // fewest grantable packets first
      for (int i = 0; i < ORDER_CNT - 1; i++) begin
         for (int k = 0; k < ORDER_CNT - 1 - i; k++) begin
            if (exp[k+1][`ENTRY_GRANTABLE] < exp[k][`ENTRY_GRANTABLE]) begin
               tmp      = exp[k];
               exp[k]   = exp[k+1];
               exp[k+1] = tmp;
            end
         end
      end
      wait_drained();
      repeat (IDLE_WAIT) @(posedge ap_clk);
      for (int i = 0; i < ORDER_CNT; i++) begin
         checker_inst.expect_grant(exp[i]);
      end
      set_grant_full(1'b0);
      wait_drained();
      repeat (IDLE_WAIT) @(posedge ap_clk);
      checker_inst.finish_test("grant_order", ORDER_CNT);
   endtask

   initial begin
      homa_hdr_pkg::homa_hdr_t hdr;
      void'($urandom(32'h457c_b69a));
      ap_rst       = 1'b1;
      grant_full_i = 1'b0;
      repeat (2) @(posedge ap_clk);
      #1;
      ap_rst = 1'b0;

      // quiet after reset
      repeat (8) @(posedge ap_clk);
      checker_inst.finish_test("reset_idle", 0);

      // one first packet, one grant
      hdr = make_header(14'h0a5, 14'h123, 10'd40, 10'd10, 32'd0);
      checker_inst.expect_grant(expected_entry(hdr, 10'd1));
      send_header(hdr);
      wait_drained();
      repeat (IDLE_WAIT) @(posedge ap_clk);
      checker_inst.finish_test("single_grant", 1);

      run_grant_order();

      // three later packets of the same message bump recv to 4
      set_grant_full(1'b1);
      hdr = make_header(14'h1ff, 14'h2bc, 10'd100, 10'd8, 32'd0);
      send_header(hdr);
      send_header(make_header(14'h1ff, 14'h2bc, 10'd100, 10'd8, 32'd1460));
      send_header(make_header(14'h1ff, 14'h2bc, 10'd100, 10'd8, 32'd2920));
      send_header(make_header(14'h1ff, 14'h2bc, 10'd100, 10'd8, 32'd4380));
      wait_drained();
      repeat (IDLE_WAIT) @(posedge ap_clk);
      checker_inst.expect_grant(expected_entry(hdr, 10'd4));
      set_grant_full(1'b0);
      wait_drained();
      repeat (IDLE_WAIT) @(posedge ap_clk);
      checker_inst.finish_test("recv_update", 4);

      // nothing to grant, and later packets with no entry to match
      send_header(make_header(14'h003, 14'h007, 10'd20, 10'd20, 32'd0));
      send_header(make_header(14'h004, 14'h008, 10'd5, 10'd30, 32'd0));
      send_header(make_header(14'h005, 14'h009, 10'd50, 10'd10, 32'd1460));
      send_header(make_header(14'h006, 14'h00a, 10'd50, 10'd10, 32'd2920));
      wait_drained();
      repeat (IDLE_WAIT) @(posedge ap_clk);
      checker_inst.finish_test("dropped_headers", 4);

      $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
               checker_inst.pass_cnt + checker_inst.fail_cnt, checker_inst.pass_cnt,
               checker_inst.fail_cnt,
               srpt_grant_top_inst.srpt_grant_props_inst.assert_fail_cnt);
      if (checker_inst.fail_cnt == 0 &&
          srpt_grant_top_inst.srpt_grant_props_inst.assert_fail_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/srpt_entry_pkg.sv
rtl/homa_hdr_pkg.sv
rtl/header_intake.sv
rtl/srpt_queue.sv
rtl/srpt_grant_top.sv
dv/srpt_grant_props.sv
dv/srpt_grant_checker.sv
dv/tb_srpt_grant.sv

// ==== Makefile ====
TOP := tb_srpt_grant

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
